/* Makefile */
# Verilator build and run of the DDC readout testbench
SIM = obj_dir/Vddc_readout_tb

all: run

build:
	verilator --binary --timing --top-module ddc_readout_tb -f ddc_readout.f

run: build
	./$(SIM)

lint:
	verilator --lint-only -Wall --timing --top-module ddc_readout_tb -f ddc_readout.f

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

/* apb_regs/ddc_apb_regs.sv */
// APB register block holding the trigger configuration and reporting event status
`timescale 1ns/1ps

module ddc_apb_regs
(
   input  logic                                   logic_clk,
   input  logic                                   reset,
   input  logic [ddc_readout_pkg::APB_ADDR_W-1:0] paddr,
   input  logic                                   psel,
   input  logic                                   penable,
   input  logic                                   pwrite,
   input  logic [ddc_readout_pkg::APB_DATA_W-1:0] pwdata,
   input  logic [ddc_readout_pkg::COUNT_W-1:0]    event_count,
   output logic [ddc_readout_pkg::APB_DATA_W-1:0] prdata,
   output logic                                   pready,
   output logic                                   pslverr,
   output logic                                   trig_en,   // Trigger enable
   output logic                                   cmp_gt,    // Greater-than mode
   output logic                                   cmp_et,    // Equal mode
   output logic                                   cmp_lt,    // Less-than mode
   output logic [ddc_readout_pkg::SAMPLE_W-1:0]   threshold,
   output logic [ddc_readout_pkg::POST_W-1:0]     post_len
);
   import ddc_readout_pkg::*;

   logic                  setup_phase;  // First cycle of a transfer
   logic                  access_phase; // Second and last cycle
   logic                  addr_hit;     // Offset is mapped
   logic                  addr_ro;      // Offset is read only
   logic                  bad_access;   // Error response
   logic [APB_DATA_W-1:0] rd_mux;

   assign setup_phase  = psel && !penable;
   assign access_phase = psel && penable;
   assign pready       = 1'b1; // Zero wait states

   ////////////////////////////////////////////////////////////
   // Address decode and read mux
   always_comb
   begin
      addr_hit = 1'b1;
      addr_ro  = 1'b0;
      rd_mux   = '0;
      case (paddr)
         REG_CTRL:
         begin
            rd_mux[CTRL_TRIG_EN] = trig_en;
            rd_mux[CTRL_GT]      = cmp_gt;
            rd_mux[CTRL_ET]      = cmp_et;
            rd_mux[CTRL_LT]      = cmp_lt;
         end
         REG_THRESHOLD:   rd_mux[SAMPLE_W-1:0] = threshold;
         REG_POST_LEN:    rd_mux[POST_W-1:0]   = post_len;
         REG_EVENT_COUNT:
         begin
            rd_mux[COUNT_W-1:0] = event_count;
            addr_ro             = 1'b1;
         end
         REG_VERSION:
         begin
            rd_mux[15:0] = VERSION;
            addr_ro      = 1'b1;
         end
         default:         addr_hit = 1'b0; // Hole in the map
      endcase
   end

   assign bad_access = !addr_hit || (pwrite && addr_ro);

   // Response is captured in setup and shown during access
   always_ff @(posedge logic_clk)
   begin
      if (reset)
      begin
         pslverr <= 1'b0;
         prdata  <= '0;
      end
      else
      begin
         pslverr <= setup_phase && bad_access;
         prdata  <= (setup_phase && !pwrite) ? rd_mux : '0;
      end
   end

   ////////////////////////////////////////////////////////////
   // Configuration registers, written at the end of access
   always_ff @(posedge logic_clk)
   begin
      if (reset)
      begin
         trig_en   <= 1'b0;
         cmp_gt    <= 1'b0;
         cmp_et    <= 1'b0;
         cmp_lt    <= 1'b0;
         threshold <= THRESHOLD_RST;
         post_len  <= POST_LEN_RST;
      end
      else if (access_phase && pwrite && !bad_access)
      begin
         case (paddr)
            REG_CTRL:
            begin
               trig_en <= pwdata[CTRL_TRIG_EN];
               cmp_gt  <= pwdata[CTRL_GT];
               cmp_et  <= pwdata[CTRL_ET];
               cmp_lt  <= pwdata[CTRL_LT];
            end
            REG_THRESHOLD: threshold <= pwdata[SAMPLE_W-1:0];
            REG_POST_LEN:  post_len  <= pwdata[POST_W-1:0];
            default:       ; // Read-only offsets never get here
         endcase
      end
   end

endmodule

/* bench/ddc_readout_cases.svh */
// Stimulus and expected-value table for the DDC readout testbench, one row per case
`ifndef DDC_READOUT_CASES_SVH
`define DDC_READOUT_CASES_SVH

// Columns
// ctrl        REG_CTRL bits {lt, et, gt, trig_en}
// threshold   REG_THRESHOLD value
// post_len    REG_POST_LEN value
// n_groups    Groups streamed before the quiet tail
// cross_lane  Lane of the forced crossing sample
// cross_cycle Group index of the crossing, negative for free random samples
// cross_val   Value of the crossing sample
// exp_headers Headers expected from the stream
// acc_addr    Offset of one extra APB access, with its direction and expected pslverr
typedef struct packed {
   logic [3:0] ctrl;
   int         threshold;
   int         post_len;
   int         n_groups;
   int         cross_lane;
   int         cross_cycle;
   int         cross_val;
   int         exp_headers;
   logic [7:0] acc_addr;
   logic       acc_write;
   logic       exp_err;
} case_t;

localparam int NUM_CASES = 6;

case_t cases [NUM_CASES] = '{
   '{4'h3, 16,   2, 24, 0, -1, 0,     6, 8'h10, 1'b0, 1'b0},  // gt, every group fires
   '{4'h3, 9000, 3, 16, 2, 5,  12000, 1, 8'h14, 1'b0, 1'b1},  // gt, hole in the map
   '{4'h5, 5000, 1, 12, 0, 3,  5000,  1, 8'h0C, 1'b1, 1'b1},  // et, write to read-only
   '{4'h9, 3000, 4, 20, 3, 8,  100,   1, 8'h0C, 1'b0, 1'b0},  // lt, event count read
   '{4'h3, 9000, 0, 10, 1, 2,  16383, 1, 8'h00, 1'b0, 1'b0},  // gt, single group events
   '{4'h2, 9000, 3, 12, 1, 4,  12000, 0, 8'h40, 1'b1, 1'b1}   // Trigger disabled
};

`endif

/* bench/ddc_readout_tb.sv */
// Testbench for the DDC readout front end, APB setup and record stream against a model
`timescale 1ns/1ps

module ddc_readout_tb;
   import ddc_readout_pkg::*;

   `include "ddc_readout_cases.svh"

   localparam logic [31:0] SEED = 32'h9fa2;

   logic                  logic_clk;
   logic                  reset;
   logic [RAW_W-1:0]      raw_word;
   logic [APB_ADDR_W-1:0] paddr;
   logic                  psel;
   logic                  penable;
   logic                  pwrite;
   logic [APB_DATA_W-1:0] pwdata;
   logic [APB_DATA_W-1:0] prdata;
   logic                  pready;
   logic                  pslverr;
   record_word_t          record_word;
   logic                  record_valid;
   logic                  recording;

   logic [RAW_W-1:0]   stream_q[$];       // Unscrambled groups, lane 0 lowest
   record_word_t       exp_q[$];          // Model output
   record_word_t       got_q[$];          // DUT output
   int                 got_cyc[$];        // Cycle stamp per DUT word
   logic [EVNUM_W-1:0] exp_evnum = '0;
   int                 cycle_count = 0;
   int                 cycle_limit;

   ddc_readout_top ddc_readout_top_inst
   (
      .logic_clk    (logic_clk),
      .reset        (reset),
      .raw_word     (raw_word),
      .paddr        (paddr),
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .pwdata       (pwdata),
      .prdata       (prdata),
      .pready       (pready),
      .pslverr      (pslverr),
      .record_word  (record_word),
      .record_valid (record_valid),
      .recording    (recording)
   );

   always #4 logic_clk = ~logic_clk; // 8 ns period

   ////////////////////////////////////////////////////////////
   // Run limit and output capture
   always @(posedge logic_clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count > cycle_limit)
      begin
         $display("Timeout, the run passed %0d cycles without finishing", cycle_limit);
         $display("Test FAILED");
         $fatal(1, "timeout");
      end
   end

   always @(negedge logic_clk)
   begin
      if (!reset && record_valid)
      begin
         got_q.push_back(record_word);
         got_cyc.push_back(cycle_count);
      end
   end

   task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp)
      begin
         $display("CHECK FAILED %s got %h expected %h", name, got, exp);
         $display("Test FAILED");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   ////////////////////////////////////////////////////////////
   // APB master, setup cycle then access cycle
   task automatic bus_access(input logic [7:0] addr, input logic wr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic err);
      @(posedge logic_clk);
      paddr   <= addr;
      pwrite  <= wr;
      pwdata  <= wdata;
      psel    <= 1'b1;
      penable <= 1'b0;
      @(posedge logic_clk);
      penable <= 1'b1;
      @(negedge logic_clk);
      rdata = prdata; // Response held through access
      err   = pslverr;
      check_value("pready", 64'(pready), 64'd1);
      @(posedge logic_clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [31:0] wdata);
      logic [31:0] rdata;
      logic        err;
      bus_access(addr, 1'b1, wdata, rdata, err);
      check_value("pslverr", 64'(err), 64'd0);
   endtask

   task automatic read_reg(input logic [7:0] addr, output logic [31:0] rdata);
      logic err;
      bus_access(addr, 1'b0, 32'h0, rdata, err);
      check_value("pslverr", 64'(err), 64'd0);
   endtask

   ////////////////////////////////////////////////////////////
   // Reference model
   function automatic logic lane_over(input logic [SAMPLE_W-1:0] s, input logic [3:0] ctrl,
                                      input logic [SAMPLE_W-1:0] thr);
      return (ctrl[1] && s > thr) || (ctrl[2] && s == thr) || (ctrl[3] && s < thr);
   endfunction

   function automatic logic [LANES-1:0] group_tot(input logic [RAW_W-1:0] g,
                                                 input logic [3:0] ctrl,
                                                 input logic [SAMPLE_W-1:0] thr);
      logic [LANES-1:0] t;
      for (int l = 0; l < LANES; l++)
         t[l] = lane_over(g[l*SAMPLE_W +: SAMPLE_W], ctrl, thr);
      return t;
   endfunction

   // Byte b holds bits 2b+1 and 2b, lane 0 in the top pair, even bit higher, all inverted
   function automatic logic [RAW_W-1:0] scramble(input logic [RAW_W-1:0] g);
      logic [RAW_W-1:0] r;
      for (int l = 0; l < LANES; l++)
      begin
         for (int b = 0; b < SAMPLE_W/2; b++)
         begin
            r[8*b + 7 - 2*l] = ~g[l*SAMPLE_W + 2*b];
            r[8*b + 6 - 2*l] = ~g[l*SAMPLE_W + 2*b + 1];
         end
      end
      return r;
   endfunction

   task automatic build_stream(input case_t c, input logic [SAMPLE_W-1:0] thr,
                               input logic [SAMPLE_W-1:0] quiet);
      logic [RAW_W-1:0]    g;
      logic [SAMPLE_W-1:0] v;
      stream_q.delete();
      for (int k = 0; k < c.n_groups; k++)
      begin
         for (int l = 0; l < LANES; l++)
         begin
            v = SAMPLE_W'($urandom);
            if (c.cross_cycle >= 0)
            begin
               while (lane_over(v, c.ctrl, thr)) // Background stays below every comparison
                  v = SAMPLE_W'($urandom);
               if (k == c.cross_cycle && l == c.cross_lane)
                  v = SAMPLE_W'(c.cross_val);
            end
            g[l*SAMPLE_W +: SAMPLE_W] = v;
         end
         stream_q.push_back(g);
      end
      for (int k = 0; k < c.post_len + 8; k++)
         stream_q.push_back({LANES{quiet}}); // Tail lets the last event drain
   endtask

   task automatic build_expected(input case_t c, input logic [SAMPLE_W-1:0] thr,
                                 output int headers);
      record_word_t w;
      int           i;
      exp_q.delete();
      headers = 0;
      i       = 0;
      while (i < stream_q.size())
      begin
         if (c.ctrl[0] && |group_tot(stream_q[i], c.ctrl, thr))
         begin
            w               = '0;
            w.hdr.tag       = TAG_HEADER;
            w.hdr.event_num = exp_evnum;
            exp_q.push_back(w);
            for (int k = 0; k <= c.post_len; k++)
            begin
               w.grp.tag     = TAG_DATA;
               w.grp.spare   = 2'b00;
               w.grp.tot     = group_tot(stream_q[i+k], c.ctrl, thr);
               w.grp.samples = stream_q[i+k];
               exp_q.push_back(w);
            end
            exp_evnum = exp_evnum + 1'b1;
            headers++;
            i += c.post_len + 2; // Idle again one group after the last data word
         end
         else
            i++;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   initial
   begin
      record_word_t        w;
      logic [31:0]         rdata;
      logic                err;
      logic [SAMPLE_W-1:0] thr;
      logic [SAMPLE_W-1:0] quiet;
      logic [TIME_W-1:0]   last_time;
      int                  last_cyc;
      int                  headers;
      int                  total_headers;
      logic                hdr_seen;
      logic_clk     = 1'b0;
      reset         = 1'b1;
      raw_word      = '0;
      paddr         = '0;
      psel          = 1'b0;
      penable       = 1'b0;
      pwrite        = 1'b0;
      pwdata        = '0;
      total_headers = 0;
      hdr_seen      = 1'b0;
      last_time     = '0;
      last_cyc      = 0;
      void'($urandom(SEED));
      cycle_limit = 200; // Reset and register checks
      for (int n = 0; n < NUM_CASES; n++)
         cycle_limit += cases[n].n_groups + cases[n].post_len + 100;

      repeat (8) @(posedge logic_clk);
      reset <= 1'b0;
      @(negedge logic_clk);
      check_value("record_valid", 64'(record_valid), 64'd0);
      check_value("recording", 64'(recording), 64'd0);
      read_reg(REG_THRESHOLD, rdata);
      check_value("threshold reset", 64'(rdata), 64'd8188);
      read_reg(REG_POST_LEN, rdata);
      check_value("post_len reset", 64'(rdata), 64'd3);
      read_reg(REG_CTRL, rdata);
      check_value("ctrl reset", 64'(rdata), 64'd0);
      read_reg(REG_VERSION, rdata);
      check_value("version", 64'(rdata), 64'({16'h0, VERSION}));

      for (int n = 0; n < NUM_CASES; n++)
      begin
         thr   = SAMPLE_W'(cases[n].threshold);
         quiet = lane_over(14'd0, cases[n].ctrl, thr) ? 14'h3fff : 14'd0;
         build_stream(cases[n], thr, quiet);
         build_expected(cases[n], thr, headers);
         check_value("model headers", 64'(headers), 64'(cases[n].exp_headers));

         // Trigger off first, the new quiet level may cross the old threshold
         write_reg(REG_CTRL, 32'h0);
         raw_word <= scramble({LANES{quiet}}); // Fills the pipeline during reconfiguration
         write_reg(REG_THRESHOLD, 32'(cases[n].threshold));
         write_reg(REG_POST_LEN, 32'(cases[n].post_len));
         write_reg(REG_CTRL, {28'h0, cases[n].ctrl});
         read_reg(REG_THRESHOLD, rdata);
         check_value("threshold", 64'(rdata), 64'(cases[n].threshold));
         read_reg(REG_POST_LEN, rdata);
         check_value("post_len", 64'(rdata), 64'(cases[n].post_len));
         read_reg(REG_CTRL, rdata);
         check_value("ctrl", 64'(rdata), 64'(cases[n].ctrl));
         check_value("stray record words", 64'(got_q.size()), 64'd0);

         foreach (stream_q[k])
         begin
            @(posedge logic_clk);
            raw_word <= scramble(stream_q[k]);
            if (!cases[n].ctrl[0])
            begin
               @(negedge logic_clk);
               check_value("recording", 64'(recording), 64'd0);
            end
         end
         while (got_q.size() < exp_q.size() || recording)
            @(negedge logic_clk);
         check_value("record word count", 64'(got_q.size()), 64'(exp_q.size()));

         foreach (exp_q[k])
         begin
            w = got_q[k];
            if (exp_q[k].hdr.tag == TAG_HEADER)
            begin
               check_value("header tag", 64'(w.hdr.tag), 64'(TAG_HEADER));
               check_value("event_num", 64'(w.hdr.event_num), 64'(exp_q[k].hdr.event_num));
               if (hdr_seen)
                  check_value("local_time step", 64'(w.hdr.local_time - last_time),
                              64'(got_cyc[k] - last_cyc));
               hdr_seen  = 1'b1;
               last_time = w.hdr.local_time;
               last_cyc  = got_cyc[k];
            end
            else
               check_value("group word", w, exp_q[k]);
         end
         got_q.delete();
         got_cyc.delete();
         total_headers += headers;

         bus_access(cases[n].acc_addr, cases[n].acc_write, 32'hffff_ffff, rdata, err);
         check_value("pslverr", 64'(err), 64'(cases[n].exp_err));
         read_reg(REG_EVENT_COUNT, rdata);
         check_value("event_count", 64'(rdata), 64'(total_headers));
      end
      check_value("stray record words", 64'(got_q.size()), 64'd0);

      $display("Test OK");
      $finish;
   end

endmodule

/* common/ddc_readout_pkg.sv */
// Shared widths, register map and record word layouts of the DDC readout front end
package ddc_readout_pkg;

   ////////////////////////////////////////////////////////////
   // Datapath widths
   localparam int SAMPLE_W = 14;                // One ADC sample
   localparam int LANES    = 4;                 // Samples per logic_clk
   localparam int RAW_W    = LANES * SAMPLE_W;  // Deserializer word, seven bytes
   localparam int TIME_W   = 48;                // Local time counter
   localparam int EVNUM_W  = 14;                // Event number in the header
   localparam int POST_W   = 8;                 // Post-trigger group count
   localparam int COUNT_W  = 16;                // Event count status

   ////////////////////////////////////////////////////////////
   // APB register map
   localparam int APB_ADDR_W = 8;
   localparam int APB_DATA_W = 32;

   localparam logic [15:0] VERSION = 16'h0201;  // Design version

   localparam logic [APB_ADDR_W-1:0] REG_CTRL        = 8'h00;
   localparam logic [APB_ADDR_W-1:0] REG_THRESHOLD   = 8'h04;
   localparam logic [APB_ADDR_W-1:0] REG_POST_LEN    = 8'h08;
   localparam logic [APB_ADDR_W-1:0] REG_EVENT_COUNT = 8'h0C; // Read only
   localparam logic [APB_ADDR_W-1:0] REG_VERSION     = 8'h10; // Read only

   // Bit positions inside REG_CTRL
   localparam int CTRL_TRIG_EN = 0;
   localparam int CTRL_GT      = 1;
   localparam int CTRL_ET      = 2;
   localparam int CTRL_LT      = 3;

   // Reset values
   localparam logic [SAMPLE_W-1:0] THRESHOLD_RST = 14'd8188; // Near mid-scale
   localparam logic [POST_W-1:0]   POST_LEN_RST  = 8'd3;

   ////////////////////////////////////////////////////////////
   // Record word layouts
   localparam logic [1:0] TAG_HEADER = 2'b01;
   localparam logic [1:0] TAG_DATA   = 2'b10;

   typedef struct packed {
      logic [1:0]         tag;        // TAG_HEADER
      logic [EVNUM_W-1:0] event_num;
      logic [TIME_W-1:0]  local_time;
   } header_word_t;

   typedef struct packed {
      logic [1:0]              tag;     // TAG_DATA
      logic [1:0]              spare;   // Always zero
      logic [LANES-1:0]        tot;     // Lane 3 on top
      logic [RAW_W-1:0]        samples; // Lane 0 lowest
   } group_word_t;

   // Same 64 bits, the tag at the top picks the view
   typedef union packed {
      header_word_t hdr;
      group_word_t  grp;
   } record_word_t;

endpackage

/* ddc_readout.f */
+incdir+bench
common/ddc_readout_pkg.sv
apb_regs/ddc_apb_regs.sv
front_end/lane_unscramble.sv
front_end/threshold_trigger.sv
record/event_framer.sv
logic/ddc_readout_top.sv
bench/ddc_readout_tb.sv

/* front_end/lane_unscramble.sv */
// First pipeline stage, restores sample bit order from the deserializer word and fixes polarity
`timescale 1ns/1ps

module lane_unscramble
(
   input  logic                                                        logic_clk,
   input  logic                                                        reset,
   input  logic [ddc_readout_pkg::RAW_W-1:0]                           raw_word,
   output logic [ddc_readout_pkg::LANES*ddc_readout_pkg::SAMPLE_W-1:0] samples
);
   import ddc_readout_pkg::*;

   logic [LANES*SAMPLE_W-1:0] samples_n; // Reordered, still inverted

   // Byte b carries sample bits 2b+1 and 2b of every lane
   // Lane 0 takes the top pair of the byte, lane 3 the bottom pair
   for (genvar l = 0; l < LANES; l++)
   begin : g_lane
      for (genvar b = 0; b < SAMPLE_W/2; b++)
      begin : g_byte
         // Even bit sits in the higher position of the pair
         assign samples_n[l*SAMPLE_W + 2*b]     = raw_word[b*2*LANES + 2*LANES-1 - 2*l];
         assign samples_n[l*SAMPLE_W + 2*b + 1] = raw_word[b*2*LANES + 2*LANES-2 - 2*l];
      end
   end

   always_ff @(posedge logic_clk)
   begin
      if (reset)
      begin
         samples <= '0;
      end
      else
      begin
         samples <= ~samples_n; // ADC lines arrive inverted
      end
   end

endmodule

/* front_end/threshold_trigger.sv */
// Second pipeline stage, per-lane time-over-threshold bits and the trigger flag
`timescale 1ns/1ps

module threshold_trigger
(
   input  logic                                                        logic_clk,
   input  logic                                                        reset,
   input  logic [ddc_readout_pkg::LANES*ddc_readout_pkg::SAMPLE_W-1:0] samples,
   input  logic                                                        trig_en,
   input  logic                                                        cmp_gt,
   input  logic                                                        cmp_et,
   input  logic                                                        cmp_lt,
   input  logic [ddc_readout_pkg::SAMPLE_W-1:0]                        threshold,
   output logic [ddc_readout_pkg::LANES*ddc_readout_pkg::SAMPLE_W-1:0] trig_samples,
   output logic [ddc_readout_pkg::LANES-1:0]                           tot,
   output logic                                                        trig
);
   import ddc_readout_pkg::*;

   logic [LANES-1:0] tot_c; // Comparator results before the register

   ////////////////////////////////////////////////////////////
   // One comparator set per lane
   for (genvar l = 0; l < LANES; l++)
   begin : g_cmp
      logic [SAMPLE_W-1:0] lane_sample;
      logic                above;
      logic                equal;
      logic                below;

      assign lane_sample = samples[l*SAMPLE_W +: SAMPLE_W];
      assign above       = lane_sample > threshold;
      assign equal       = lane_sample == threshold;
      assign below       = lane_sample < threshold;

      // Any enabled comparison that holds sets TOT
      assign tot_c[l] = (cmp_gt && above) || (cmp_et && equal) || (cmp_lt && below);
   end

   // Samples follow their TOT bits by the same one cycle
   always_ff @(posedge logic_clk)
   begin
      trig_samples <= samples;
   end

   always_ff @(posedge logic_clk)
   begin
      if (reset)
      begin
         tot  <= '0;
         trig <= 1'b0;
      end
      else
      begin
         tot  <= tot_c;
         trig <= trig_en && (|tot_c); // Any lane over threshold
      end
   end

endmodule

/* logic/ddc_readout_top.sv */
// Top level of the DDC readout front end, APB registers feeding the three-stage pipeline
`timescale 1ns/1ps

module ddc_readout_top
(
   input  logic                                   logic_clk,
   input  logic                                   reset,
   input  logic [ddc_readout_pkg::RAW_W-1:0]      raw_word,     // From deserializer
   input  logic [ddc_readout_pkg::APB_ADDR_W-1:0] paddr,
   input  logic                                   psel,
   input  logic                                   penable,
   input  logic                                   pwrite,
   input  logic [ddc_readout_pkg::APB_DATA_W-1:0] pwdata,
   output logic [ddc_readout_pkg::APB_DATA_W-1:0] prdata,
   output logic                                   pready,
   output logic                                   pslverr,
   output ddc_readout_pkg::record_word_t          record_word,
   output logic                                   record_valid,
   output logic                                   recording     // Trigger-out analogue
);
   import ddc_readout_pkg::*;

   // Configuration and status
   logic                  trig_en;
   logic                  cmp_gt;
   logic                  cmp_et;
   logic                  cmp_lt;
   logic [SAMPLE_W-1:0]   threshold;
   logic [POST_W-1:0]     post_len;
   logic [COUNT_W-1:0]    event_count;

   // Pipeline between stages
   logic [LANES*SAMPLE_W-1:0] samples;      // After unscramble
   logic [LANES*SAMPLE_W-1:0] trig_samples; // Aligned with tot
   logic [LANES-1:0]          tot;
   logic                      trig;

   ////////////////////////////////////////////////////////////
   ddc_apb_regs ddc_apb_regs_inst
   (
      .logic_clk   (logic_clk),
      .reset       (reset),
      .paddr       (paddr),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .pwdata      (pwdata),
      .event_count (event_count),
      .prdata      (prdata),
      .pready      (pready),
      .pslverr     (pslverr),
      .trig_en     (trig_en),
      .cmp_gt      (cmp_gt),
      .cmp_et      (cmp_et),
      .cmp_lt      (cmp_lt),
      .threshold   (threshold),
      .post_len    (post_len)
   );

   lane_unscramble lane_unscramble_inst
   (
      .logic_clk (logic_clk),
      .reset     (reset),
      .raw_word  (raw_word),
      .samples   (samples)
   );

   threshold_trigger threshold_trigger_inst
   (
      .logic_clk    (logic_clk),
      .reset        (reset),
      .samples      (samples),
      .trig_en      (trig_en),
      .cmp_gt       (cmp_gt),
      .cmp_et       (cmp_et),
      .cmp_lt       (cmp_lt),
      .threshold    (threshold),
      .trig_samples (trig_samples),
      .tot          (tot),
      .trig         (trig)
   );

   event_framer event_framer_inst
   (
      .logic_clk    (logic_clk),
      .reset        (reset),
      .trig_samples (trig_samples),
      .tot          (tot),
      .trig         (trig),
      .post_len     (post_len),
      .record_word  (record_word),
      .record_valid (record_valid),
      .recording    (recording),
      .event_count  (event_count)
   );

endmodule

/* record/event_framer.sv */
// Third pipeline stage, local time counter and framing of events into header and group words
`timescale 1ns/1ps

module event_framer
(
   input  logic                                                        logic_clk,
   input  logic                                                        reset,
   input  logic [ddc_readout_pkg::LANES*ddc_readout_pkg::SAMPLE_W-1:0] trig_samples,
   input  logic [ddc_readout_pkg::LANES-1:0]                           tot,
   input  logic                                                        trig,
   input  logic [ddc_readout_pkg::POST_W-1:0]                          post_len,
   output ddc_readout_pkg::record_word_t                               record_word,
   output logic                                                        record_valid,
   output logic                                                        recording,
   output logic [ddc_readout_pkg::COUNT_W-1:0]                         event_count
);
   import ddc_readout_pkg::*;

   logic [TIME_W-1:0]         local_time;  // Cycles since reset release
   logic [EVNUM_W-1:0]        event_num;   // Number for the next header
   logic [LANES-1:0]          tot_q;       // Delayed group TOT bits
   logic [LANES*SAMPLE_W-1:0] samples_q;   // Delayed group samples
   logic [POST_W-1:0]         groups_left; // Group words still to send after this one
   logic                      start_event; // Idle and triggered

   assign start_event = !recording && trig;

   ////////////////////////////////////////////////////////////
   // Local time
   always_ff @(posedge logic_clk)
   begin
      if (reset)
      begin
         local_time <= '0;
      end
      else
      begin
         local_time <= local_time + 1'b1;
      end
   end

   // One-group delay so the trigger group follows its header
   always_ff @(posedge logic_clk)
   begin
      tot_q     <= tot;
      samples_q <= trig_samples;
   end

   ////////////////////////////////////////////////////////////
   // Event control
   always_ff @(posedge logic_clk)
   begin
      if (reset)
      begin
         record_valid <= 1'b0;
         recording    <= 1'b0;
         groups_left  <= '0;
         event_num    <= '0;
         event_count  <= '0;
      end
      else
      begin
         record_valid <= start_event || recording; // Header or group word
         if (start_event)
         begin
            recording   <= 1'b1;
            groups_left <= post_len;           // post_len+1 groups in total
            event_num   <= event_num + 1'b1;   // Wraps at 14 bits
            event_count <= event_count + 1'b1;
         end
         else if (recording)
         begin
            if (groups_left == '0)
            begin
               recording <= 1'b0; // Last group goes out now
            end
            else
            begin
               groups_left <= groups_left - 1'b1;
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Record word through the header or the group view
   always_ff @(posedge logic_clk)
   begin
      if (start_event)
      begin
         record_word.hdr.tag        <= TAG_HEADER;
         record_word.hdr.event_num  <= event_num;
         record_word.hdr.local_time <= local_time;
      end
      else
      begin
         record_word.grp.tag     <= TAG_DATA;
         record_word.grp.spare   <= '0;
         record_word.grp.tot     <= tot_q;
         record_word.grp.samples <= samples_q; // Qualified by record_valid
      end
   end

endmodule
